// ==== au_consts.svh ====
/*
  Arithmetic cluster constants
  Geometry of the barrel-threaded arithmetic block: slice count,
  register file depth, datapath widths and flag bit positions.
*/

`ifndef AU_CONSTS_SVH
`define AU_CONSTS_SVH

// Hardware threads and registers per thread
`define AU_NUM_SLICES 4
`define AU_NUM_REGS 16

// Register value width
`define AU_WORD_W 32

// Instruction word width
`define AU_OP_W 15

// Bit positions inside a slice's flag register
`define AU_FLAG_ZERO 0
`define AU_FLAG_NEG 1
`define AU_FLAG_OVFL 2

`endif

// ==== au_isa_pkg.sv ====
/*
  Arithmetic instruction set types
  Register values, extended 33-bit results, register selects,
  instruction words and the condition flag vector.
*/

`default_nettype none

`include "au_consts.svh"

package au_isa_pkg;

  // One register value
  typedef logic [`AU_WORD_W-1:0] word_t;

  // Result with one extra top bit for sign or carry-out
  typedef logic [`AU_WORD_W:0] ext_word_t;

  // Register number within one slice's file
  typedef logic [$clog2(`AU_NUM_REGS)-1:0] reg_sel_t;

  // Raw instruction word
  //   [14:12] 000 two-register, 001 bit/shift
  //   [14:13] non-zero marks an immediate instruction
  typedef logic [`AU_OP_W-1:0] au_op_t;

  // Zero, negative and overflow
  typedef logic [`AU_FLAG_OVFL:0] flags_t;

endpackage

`default_nettype wire

// ==== au_slice_pkg.sv ====
/*
  Slice types
  Slice numbers and one-bit-per-slice masks for the thread scheduler.
*/

`default_nettype none

`include "au_consts.svh"

package au_slice_pkg;

  // Hardware thread number
  typedef logic [$clog2(`AU_NUM_SLICES)-1:0] slice_t;

  // One bit per hardware thread
  typedef logic [`AU_NUM_SLICES-1:0] slice_mask_t;

endpackage

`default_nettype wire

// ==== slice_scheduler.sv ====
/*
  Slice scheduler
  Holds one pending instruction per slice and rotates the turn
  counter every clock. A full slot issues when its slice's turn
  comes up and empties at the end of that cycle.
*/

`timescale 1ns/1ps
`default_nettype none

`include "au_consts.svh"

module slice_scheduler (
  input  wire                          CLK,
  input  wire                          RST,
  input  wire au_slice_pkg::slice_t    op_slice,
  input  wire                          op_vld,
  input  wire au_isa_pkg::au_op_t      op,
  output au_slice_pkg::slice_t         cur_slice,
  output au_slice_pkg::slice_mask_t    pending,
  output logic                         issue_vld,
  output au_isa_pkg::au_op_t           issue_op
);

  import au_isa_pkg::*;
  import au_slice_pkg::*;

  au_op_t      slot_op [`AU_NUM_SLICES];
  slice_mask_t wr_mask;
  slice_mask_t issue_mask;

  // Turn counter wraps through all slices
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      cur_slice <= '0;
    else
      cur_slice <= cur_slice + 1'b1;
  end

  assign issue_vld = pending[cur_slice];
  assign issue_op  = slot_op[cur_slice];

  assign wr_mask    = op_vld ? (slice_mask_t'(1) << op_slice) : '0;
  assign issue_mask = issue_vld ? (slice_mask_t'(1) << cur_slice) : '0;

  // A new write wins over the issue clear, so a same-cycle refill sticks
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      pending <= '0;
    else
      pending <= (pending & ~issue_mask) | wr_mask;
  end

  // Slot payload
  always_ff @(posedge CLK)
  begin
    if (op_vld)
      slot_op[op_slice] <= op;
  end

endmodule

`default_nettype wire

// ==== slice_context.sv ====
/*
  Slice context
  One hardware thread's 16-entry register file and its condition
  flags. Writebacks and flag updates are accepted only when they
  are tagged with this slice's own index.
*/

`timescale 1ns/1ps
`default_nettype none

`include "au_consts.svh"

module slice_context (
  input  wire                        CLK,
  input  wire                        RST,
  input  wire au_slice_pkg::slice_t  slice_idx,
  input  wire                        wr_vld,
  input  wire au_slice_pkg::slice_t  wr_slice,
  input  wire au_isa_pkg::reg_sel_t  wr_sel,
  input  wire au_isa_pkg::word_t     wr_data,
  input  wire                        flag_vld,
  input  wire au_slice_pkg::slice_t  flag_wr_slice,
  input  wire au_isa_pkg::flags_t    flag_val,
  output au_isa_pkg::word_t          regs [`AU_NUM_REGS],
  output au_isa_pkg::flags_t         flags_out
);

  logic rf_we;
  logic flag_we;

  // Tag match against this copy's slice number
  assign rf_we   = wr_vld && (wr_slice == slice_idx);
  assign flag_we = flag_vld && (flag_wr_slice == slice_idx);

  // Register file comes out of reset all zero
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int i = 0; i < `AU_NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (rf_we)
      regs[wr_sel] <= wr_data;
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      flags_out <= '0;
    else if (flag_we)
      flags_out <= flag_val;
  end

endmodule

`default_nettype wire

// ==== context_read_mux.sv ====
/*
  Context read mux
  Picks the issuing slice's register file, reads both operands
  from it, and returns the flags of the slice asked for outside.
*/

`timescale 1ns/1ps
`default_nettype none

`include "au_consts.svh"

module context_read_mux (
  input  wire au_slice_pkg::slice_t  cur_slice,
  input  wire au_isa_pkg::reg_sel_t  ra_sel,
  input  wire au_isa_pkg::reg_sel_t  rb_sel,
  input  wire au_isa_pkg::word_t     slice_regs [`AU_NUM_SLICES][`AU_NUM_REGS],
  input  wire au_isa_pkg::flags_t    slice_flags [`AU_NUM_SLICES],
  input  wire au_slice_pkg::slice_t  flag_slice,
  output au_isa_pkg::word_t          ra,
  output au_isa_pkg::word_t          rb,
  output au_isa_pkg::flags_t         flags
);

  import au_isa_pkg::*;

  word_t cur_regs [`AU_NUM_REGS];

  // Register file of the slice holding the turn
  assign cur_regs = slice_regs[cur_slice];

  assign ra = cur_regs[ra_sel];
  assign rb = cur_regs[rb_sel];

  // Flag readback is independent of the turn
  assign flags = slice_flags[flag_slice];

endmodule

`default_nettype wire

// ==== au_pipeline.sv ====
/*
  Arithmetic pipeline
  Decodes two-register, bit/shift and immediate instructions,
  reads operands in the issue cycle and computes a 33-bit result
  over two registered stages. Writebacks and flag updates carry
  the number of the slice that issued them.
*/

`timescale 1ns/1ps
`default_nettype none

`include "au_consts.svh"

module au_pipeline (
  input  wire                        CLK,
  input  wire                        RST,
  input  wire au_slice_pkg::slice_t  cur_slice,
  input  wire                        issue_vld,
  input  wire au_isa_pkg::au_op_t    issue_op,
  output au_isa_pkg::reg_sel_t       ra_sel,
  output au_isa_pkg::reg_sel_t       rb_sel,
  input  wire au_isa_pkg::word_t     ra,
  input  wire au_isa_pkg::word_t     rb,
  output logic                       rc_vld,
  output au_slice_pkg::slice_t       rc_slice,
  output au_isa_pkg::reg_sel_t       rc_sel,
  output au_isa_pkg::word_t          rc,
  output logic                       flag_vld,
  output au_slice_pkg::slice_t       flag_wr_slice,
  output au_isa_pkg::flags_t         flag_val
);

  import au_isa_pkg::*;
  import au_slice_pkg::*;

  function automatic ext_word_t sext(input word_t w);
    return {w[`AU_WORD_W-1], w};
  endfunction

  logic      is_tworeg;
  logic      is_bitop;
  logic      is_imm;
  logic      wb_en;
  word_t     opnd_b;
  logic      vld_d1;
  logic      bitop_d1;
  logic      imm_d1;
  logic      wb_d1;
  word_t     a_d1;
  word_t     b_d1;
  logic [3:0] cmd_d1;
  slice_t    slice_d1;
  reg_sel_t  sel_d1;
  ext_word_t a_x;
  ext_word_t b_x;
  logic [2:0] bit_cmd;
  logic [4:0] bit_sel;
  ext_word_t ext_mask;
  ext_word_t tworeg_res;
  ext_word_t bitop_res;
  ext_word_t imm_res;
  ext_word_t res_sel;
  logic      vld_d2;
  logic      wb_d2;
  ext_word_t res_d2;
  slice_t    slice_d2;
  reg_sel_t  sel_d2;

  // Issue cycle decode
  assign is_tworeg = issue_op[14:12] == 3'b000;
  assign is_bitop  = issue_op[14:12] == 3'b001;
  assign is_imm    = |issue_op[14:13];
  assign ra_sel    = issue_op[3:0];
  assign rb_sel    = issue_op[7:4];

  // Both compare forms leave the register file alone
  assign wb_en = (is_tworeg && (issue_op[11:8] != 4'h5)) || is_bitop ||
                 (is_imm && (issue_op[14:13] != 2'b01));

  // Operand B is the register, the immediate or the packed bit-op fields
  always_comb
  begin
    if (is_imm)
      opnd_b = {{(`AU_WORD_W-9){issue_op[12]}}, issue_op[12:4]};
    else if (is_bitop)
      opnd_b = {{(`AU_WORD_W-8){1'b0}}, issue_op[11:4]};
    else
      opnd_b = rb;
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      vld_d1   <= 1'b0;
      bitop_d1 <= 1'b0;
      imm_d1   <= 1'b0;
      wb_d1    <= 1'b0;
      vld_d2   <= 1'b0;
      wb_d2    <= 1'b0;
    end
    else
    begin
      vld_d1   <= issue_vld;
      bitop_d1 <= issue_vld && is_bitop;
      imm_d1   <= issue_vld && is_imm;
      wb_d1    <= issue_vld && wb_en;
      vld_d2   <= vld_d1;
      wb_d2    <= wb_d1;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (issue_vld)
    begin
      a_d1     <= ra;
      b_d1     <= opnd_b;
      cmd_d1   <= is_imm ? {2'b00, issue_op[14:13]} : issue_op[11:8];
      slice_d1 <= cur_slice;
      sel_d1   <= issue_op[3:0];
    end
  end

  // Stage 1 operands
  assign a_x      = sext(a_d1);
  assign b_x      = sext(b_d1);
  assign bit_cmd  = b_d1[7:5];
  assign bit_sel  = b_d1[4:0];
  assign ext_mask = {(`AU_WORD_W+1){1'b1}} << bit_sel;

  always_comb
  begin
    case (cmd_d1)
      4'h0: tworeg_res = {1'b0, a_d1 | b_d1};
      4'h1: tworeg_res = {1'b0, a_d1 & b_d1};
      4'h2: tworeg_res = {1'b0, a_d1 ^ b_d1};
      4'h3: tworeg_res = a_x + b_x;
      4'h4, 4'h5: tworeg_res = a_x - b_x;
      4'h8: tworeg_res = b_x;
      4'h9: tworeg_res = ~b_x;
      4'hA: tworeg_res = ext_word_t'(0) - b_x;
      default: tworeg_res = '0;
    endcase
  end

  // Sign-extend fills from the chosen bit upward, top bit included
  always_comb
  begin
    case (bit_cmd)
      3'd0: bitop_res = {1'b0, a_d1 | (word_t'(1) << bit_sel)};
      3'd1: bitop_res = {1'b0, a_d1 & ~(word_t'(1) << bit_sel)};
      3'd4: bitop_res = {1'b0, a_d1} << bit_sel;
      3'd5: bitop_res = {1'b0, a_d1} >> bit_sel;
      3'd6: bitop_res = $signed(a_x) >>> bit_sel;
      3'd7: bitop_res = a_d1[bit_sel] ? ({1'b0, a_d1} | ext_mask) : ({1'b0, a_d1} & ~ext_mask);
      default: bitop_res = '0;
    endcase
  end

  always_comb
  begin
    case (cmd_d1[1:0])
      2'b01: imm_res = a_x - b_x;
      2'b10: imm_res = a_x + b_x;
      2'b11: imm_res = b_x;
      default: imm_res = '0;
    endcase
  end

  assign res_sel = imm_d1 ? imm_res : (bitop_d1 ? bitop_res : tworeg_res);

  always_ff @(posedge CLK)
  begin
    if (vld_d1)
    begin
      res_d2   <= res_sel;
      slice_d2 <= slice_d1;
      sel_d2   <= sel_d1;
    end
  end

  // Writeback and flag update, tagged with the issuing slice
  assign rc_vld        = wb_d2;
  assign rc_slice      = slice_d2;
  assign rc_sel        = sel_d2;
  assign rc            = res_d2[`AU_WORD_W-1:0];
  assign flag_vld      = vld_d2;
  assign flag_wr_slice = slice_d2;

  always_comb
  begin
    flag_val[`AU_FLAG_ZERO] = ~|res_d2[`AU_WORD_W-1:0];
    flag_val[`AU_FLAG_NEG]  = res_d2[`AU_WORD_W-1];
    flag_val[`AU_FLAG_OVFL] = res_d2[`AU_WORD_W] ^ res_d2[`AU_WORD_W-1];
  end

endmodule

`default_nettype wire

// ==== au_cluster.sv ====
/*
  Arithmetic cluster top level
  Four barrel-threaded slices share one arithmetic pipeline. The
  scheduler issues pending instructions in turn, the read mux feeds
  operands from the issuing slice, and results return by slice tag.
*/

`timescale 1ns/1ps
`default_nettype none

`include "au_consts.svh"

module au_cluster (
  input  wire                          CLK,
  input  wire                          RST,
  input  wire                          op_vld,
  input  wire au_slice_pkg::slice_t    op_slice,
  input  wire au_isa_pkg::au_op_t      op,
  input  wire au_slice_pkg::slice_t    flag_slice,
  output au_slice_pkg::slice_mask_t    pending,
  output logic                         rc_vld,
  output au_slice_pkg::slice_t         rc_slice,
  output au_isa_pkg::reg_sel_t         rc_sel,
  output au_isa_pkg::word_t            rc,
  output au_isa_pkg::flags_t           flags
);

  import au_isa_pkg::*;
  import au_slice_pkg::*;

  slice_t   cur_slice;
  logic     issue_vld;
  au_op_t   issue_op;
  reg_sel_t ra_sel;
  reg_sel_t rb_sel;
  word_t    ra;
  word_t    rb;
  logic     flag_vld;
  slice_t   flag_wr_slice;
  flags_t   flag_val;
  word_t    ctx_regs [`AU_NUM_SLICES][`AU_NUM_REGS];
  flags_t   ctx_flags [`AU_NUM_SLICES];

  slice_scheduler u_slice_scheduler (
    .CLK       (CLK),
    .RST       (RST),
    .op_slice  (op_slice),
    .op_vld    (op_vld),
    .op        (op),
    .cur_slice (cur_slice),
    .pending   (pending),
    .issue_vld (issue_vld),
    .issue_op  (issue_op)
  );

  // One context per hardware thread
  for (genvar g = 0; g < `AU_NUM_SLICES; g++)
  begin : g_ctx
    slice_context u_slice_context (
      .CLK           (CLK),
      .RST           (RST),
      .slice_idx     (slice_t'(g)),
      .wr_vld        (rc_vld),
      .wr_slice      (rc_slice),
      .wr_sel        (rc_sel),
      .wr_data       (rc),
      .flag_vld      (flag_vld),
      .flag_wr_slice (flag_wr_slice),
      .flag_val      (flag_val),
      .regs          (ctx_regs[g]),
      .flags_out     (ctx_flags[g])
    );
  end

  context_read_mux u_context_read_mux (
    .cur_slice   (cur_slice),
    .ra_sel      (ra_sel),
    .rb_sel      (rb_sel),
    .slice_regs  (ctx_regs),
    .slice_flags (ctx_flags),
    .flag_slice  (flag_slice),
    .ra          (ra),
    .rb          (rb),
    .flags       (flags)
  );

  au_pipeline u_au_pipeline (
    .CLK           (CLK),
    .RST           (RST),
    .cur_slice     (cur_slice),
    .issue_vld     (issue_vld),
    .issue_op      (issue_op),
    .ra_sel        (ra_sel),
    .rb_sel        (rb_sel),
    .ra            (ra),
    .rb            (rb),
    .rc_vld        (rc_vld),
    .rc_slice      (rc_slice),
    .rc_sel        (rc_sel),
    .rc            (rc),
    .flag_vld      (flag_vld),
    .flag_wr_slice (flag_wr_slice),
    .flag_val      (flag_val)
  );

endmodule

`default_nettype wire

// ==== au_cluster_checker.sv ====
/*
  Arithmetic cluster checker
  Timing rules of the top level: slot bits are set only by a write
  strobe, a full slot drains within one round of turns, and the
  writeback strobe stays known once out of reset.
*/

`timescale 1ns/1ps
`default_nettype none

module au_cluster_checker (
  input wire                             CLK,
  input wire                             RST,
  input wire                             op_vld,
  input wire au_slice_pkg::slice_t       op_slice,
  input wire au_slice_pkg::slice_mask_t  pending,
  input wire                             rc_vld
);

  import au_slice_pkg::*;

  // Failure count, read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  // A rising slot bit needs a write to that slice one edge earlier
  a_set_by_write: assert property (@(posedge CLK) disable iff (RST)
    ((pending & ~$past(pending)) == '0) ||
    ($past(op_vld) && ((pending & ~$past(pending)) == (slice_mask_t'(1) << $past(op_slice)))))
  else
  begin
    $error("pending bit set without a matching op_vld");
    fail_cnt++;
  end

  // Four samples high at most, then the turn has come round
  a_drain_in_time: assert property (@(posedge CLK) disable iff (RST)
    ~|(pending & $past(pending, 1) & $past(pending, 2) & $past(pending, 3) & $past(pending, 4)))
  else
  begin
    $error("pending bit held longer than four cycles");
    fail_cnt++;
  end

  a_rc_vld_known: assert property (@(posedge CLK) disable iff (RST) !$isunknown(rc_vld))
  else
  begin
    $error("rc_vld is unknown");
    fail_cnt++;
  end

endmodule

`default_nettype wire

// ==== au_cluster_tb.sv ====
/*
  Arithmetic cluster testbench
  Applies a table of instructions to the cluster, one at a time, and
  checks writebacks, slice tags, latency and flags against expected
  values worked out from the instruction set rules.
*/

`timescale 1ns/1ps
`default_nettype none

`include "au_consts.svh"

module au_cluster_tb;

  import au_isa_pkg::*;
  import au_slice_pkg::*;

  // One stimulus row; chain means the next row follows without settling
  typedef struct packed {
    slice_t slice;
    au_op_t op;
    logic   wb;
    word_t  val;
    flags_t flg;
    logic   chain;
  } row_t;

  typedef struct packed {
    int unsigned cyc;
    slice_t      slice;
    reg_sel_t    sel;
    word_t       val;
  } wb_t;

  logic        CLK;
  logic        RST;
  logic        op_vld;
  slice_t      op_slice;
  au_op_t      op;
  slice_t      flag_slice;
  slice_mask_t pending;
  logic        rc_vld;
  slice_t      rc_slice;
  reg_sel_t    rc_sel;
  word_t       rc;
  flags_t      flags;

  row_t        rows[$];
  wb_t         wb_q[$];
  int unsigned issue_cyc[$];
  int unsigned cyc = 0;
  int          seed = 61;
  logic        table_built = 1'b0;

  au_cluster u_au_cluster (
    .CLK        (CLK),
    .RST        (RST),
    .op_vld     (op_vld),
    .op_slice   (op_slice),
    .op         (op),
    .flag_slice (flag_slice),
    .pending    (pending),
    .rc_vld     (rc_vld),
    .rc_slice   (rc_slice),
    .rc_sel     (rc_sel),
    .rc         (rc),
    .flags      (flags)
  );

  bind au_cluster au_cluster_checker u_au_cluster_checker (
    .CLK      (CLK),
    .RST      (RST),
    .op_vld   (op_vld),
    .op_slice (op_slice),
    .pending  (pending),
    .rc_vld   (rc_vld)
  );

  initial
  begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK)
    cyc <= cyc + 1;

  // Every writeback is logged with the cycle it was seen in
  always @(negedge CLK)
  begin
    if (rc_vld)
      wb_q.push_back({cyc, rc_slice, rc_sel, rc});
  end

  function automatic au_op_t enc_rr(input logic [3:0] cmd, input reg_sel_t b, input reg_sel_t a);
    return {3'b000, cmd, b, a};
  endfunction

  function automatic au_op_t enc_bit(input logic [2:0] cmd, input logic [4:0] n,
                                     input reg_sel_t a);
    return {3'b001, cmd, n, a};
  endfunction

  function automatic au_op_t enc_imm(input logic [1:0] cmd, input logic [8:0] imm,
                                     input reg_sel_t a);
    return {cmd, imm, a};
  endfunction

  task automatic add_row(input slice_t s, input au_op_t o, input logic wb, input word_t v,
                         input flags_t f, input logic ch);
    rows.push_back({s, o, wb, v, f, ch});
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at the first wrong value");
    end
  endtask

  task automatic build_table();
    int         r;
    logic [8:0] imm;
    flags_t     f;
    // Immediate load and add, slice 0
    add_row(2'd0, enc_imm(2'b11, 9'h1FB, 4'd1), 1'b1, 32'hFFFFFFFB, 3'b010, 1'b0);
    add_row(2'd0, enc_imm(2'b11, 9'h064, 4'd2), 1'b1, 32'h00000064, 3'b000, 1'b0);
    add_row(2'd0, enc_imm(2'b10, 9'h005, 4'd1), 1'b1, 32'h00000000, 3'b001, 1'b0);
    add_row(2'd0, enc_imm(2'b10, 9'h0FF, 4'd2), 1'b1, 32'h00000163, 3'b000, 1'b0);
    add_row(2'd0, enc_imm(2'b11, 9'h0F0, 4'd3), 1'b1, 32'h000000F0, 3'b000, 1'b0);
    add_row(2'd0, enc_imm(2'b01, 9'h0F0, 4'd3), 1'b0, 32'h0, 3'b001, 1'b0);
    // Two-register commands
    add_row(2'd0, enc_imm(2'b11, 9'h0AA, 4'd4), 1'b1, 32'h000000AA, 3'b000, 1'b0);
    add_row(2'd0, enc_rr(4'h8, 4'd3, 4'd5), 1'b1, 32'h000000F0, 3'b000, 1'b0);
    add_row(2'd0, enc_rr(4'h0, 4'd4, 4'd5), 1'b1, 32'h000000FA, 3'b000, 1'b0);
    add_row(2'd0, enc_rr(4'h1, 4'd3, 4'd5), 1'b1, 32'h000000F0, 3'b000, 1'b0);
    add_row(2'd0, enc_rr(4'h2, 4'd4, 4'd5), 1'b1, 32'h0000005A, 3'b000, 1'b0);
    add_row(2'd0, enc_rr(4'h3, 4'd4, 4'd5), 1'b1, 32'h00000104, 3'b000, 1'b0);
    add_row(2'd0, enc_rr(4'h4, 4'd3, 4'd5), 1'b1, 32'h00000014, 3'b000, 1'b0);
    add_row(2'd0, enc_rr(4'h5, 4'd3, 4'd5), 1'b0, 32'h0, 3'b010, 1'b0);
    add_row(2'd0, enc_rr(4'h9, 4'd4, 4'd6), 1'b1, 32'hFFFFFF55, 3'b010, 1'b0);
    add_row(2'd0, enc_rr(4'hA, 4'd4, 4'd7), 1'b1, 32'hFFFFFF56, 3'b010, 1'b0);
    add_row(2'd0, enc_rr(4'h8, 4'd5, 4'd8), 1'b1, 32'h00000014, 3'b000, 1'b0);
    add_row(2'd0, enc_rr(4'hF, 4'd0, 4'd8), 1'b1, 32'h00000000, 3'b001, 1'b0);
    // Bit and shift commands, plus the overflowing add
    add_row(2'd0, enc_imm(2'b11, 9'h001, 4'd9), 1'b1, 32'h00000001, 3'b000, 1'b0);
    add_row(2'd0, enc_bit(3'd4, 5'd30, 4'd9), 1'b1, 32'h40000000, 3'b000, 1'b0);
    add_row(2'd0, enc_rr(4'h8, 4'd9, 4'd10), 1'b1, 32'h40000000, 3'b000, 1'b0);
    add_row(2'd0, enc_rr(4'h3, 4'd9, 4'd10), 1'b1, 32'h80000000, 3'b110, 1'b0);
    add_row(2'd0, enc_bit(3'd0, 5'd4, 4'd11), 1'b1, 32'h00000010, 3'b000, 1'b0);
    add_row(2'd0, enc_bit(3'd0, 5'd31, 4'd11), 1'b1, 32'h80000010, 3'b110, 1'b0);
    add_row(2'd0, enc_bit(3'd1, 5'd4, 4'd11), 1'b1, 32'h80000000, 3'b110, 1'b0);
    add_row(2'd0, enc_bit(3'd5, 5'd4, 4'd11), 1'b1, 32'h08000000, 3'b000, 1'b0);
    add_row(2'd0, enc_bit(3'd6, 5'd4, 4'd6), 1'b1, 32'hFFFFFFF5, 3'b010, 1'b0);
    add_row(2'd0, enc_bit(3'd7, 5'd8, 4'd2), 1'b1, 32'hFFFFFF63, 3'b010, 1'b0);
    add_row(2'd0, enc_bit(3'd7, 5'd3, 4'd5), 1'b1, 32'h00000004, 3'b000, 1'b0);
    add_row(2'd0, enc_bit(3'd4, 5'd1, 4'd9), 1'b1, 32'h80000000, 3'b110, 1'b0);
    add_row(2'd0, enc_bit(3'd4, 5'd1, 4'd9), 1'b1, 32'h00000000, 3'b101, 1'b0);
    add_row(2'd0, enc_bit(3'd2, 5'd0, 4'd11), 1'b1, 32'h00000000, 3'b001, 1'b0);
    // Load then dependent add on slice 1, issued on the very next turn
    add_row(2'd1, enc_imm(2'b11, 9'h007, 4'd1), 1'b1, 32'h00000007, 3'b000, 1'b1);
    add_row(2'd1, enc_imm(2'b10, 9'h003, 4'd1), 1'b1, 32'h0000000A, 3'b000, 1'b0);
    // Random loads into r12 of every slice back to back
    // The flag readback at the end expects these as the last rows
    for (int s = 0; s < `AU_NUM_SLICES; s++)
    begin
      r = $random(seed);
      imm = r[8:0];
      f = '0;
      f[`AU_FLAG_ZERO] = (imm == 9'd0);
      f[`AU_FLAG_NEG] = imm[8];
      add_row(slice_t'(s), enc_imm(2'b11, imm, 4'd12), 1'b1, {{23{imm[8]}}, imm}, f,
              (s < `AU_NUM_SLICES - 1));
    end
  endtask

  task automatic apply_row(input int i);
    @(posedge CLK);
    op_vld     <= 1'b1;
    op_slice   <= rows[i].slice;
    op         <= rows[i].op;
    flag_slice <= rows[i].slice;
    @(posedge CLK);
    op_vld <= 1'b0;
    @(negedge CLK);
    // Only the slot just written is full
    check_value("pending", pending, slice_mask_t'(1) << rows[i].slice);
    while (pending[rows[i].slice])
      @(negedge CLK);
    issue_cyc.push_back(cyc);
  endtask

  // Writebacks arrive one edge after the slot empties
  task automatic check_group(input int first, input int last);
    int  n_wb;
    wb_t w;
    n_wb = 0;
    for (int j = first; j <= last; j++)
      n_wb += rows[j].wb;
    check_value("writeback count", wb_q.size(), n_wb);
    for (int j = first; j <= last; j++)
    begin
      if (rows[j].wb)
      begin
        w = wb_q.pop_front();
        check_value("rc", w.val, rows[j].val);
        check_value("rc_slice", w.slice, rows[j].slice);
        check_value("rc_sel", w.sel, rows[j].op[3:0]);
        check_value("writeback latency", w.cyc - issue_cyc[j], 1);
      end
    end
    check_value("flags", flags, rows[last].flg);
  endtask

  initial
  begin
    int first;
    RST        = 1'b1;
    op_vld     = 1'b0;
    op_slice   = '0;
    op         = '0;
    flag_slice = '0;
    build_table();
    table_built = 1'b1;
    repeat (10) @(posedge CLK);
    RST <= 1'b0;
    first = 0;
    for (int i = 0; i < rows.size(); i++)
    begin
      apply_row(i);
      if (!rows[i].chain)
      begin
        repeat (3) @(posedge CLK);
        #1;
        check_group(first, i);
        first = i + 1;
      end
    end
    // Each slice still holds the flags of its own random load
    for (int s = 0; s < `AU_NUM_SLICES; s++)
    begin
      @(posedge CLK);
      flag_slice <= slice_t'(s);
      @(negedge CLK);
      check_value("flags readback", flags, rows[rows.size() - `AU_NUM_SLICES + s].flg);
    end
    if (u_au_cluster.u_au_cluster_checker.fail_cnt == 0)
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
    else
    begin
      $display("Simulation finished: FAIL");
      $fatal(1, "timing assertions failed during the run");
    end
  end

  // Budget of 20 cycles per row on top of the reset time
  initial
  begin
    wait (table_built === 1'b1);
    #((rows.size() * 20 + 10) * 8);
    $display("timeout: the run did not finish in the expected time");
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== au_cluster.f ====
+incdir+.
au_isa_pkg.sv
au_slice_pkg.sv
slice_scheduler.sv
slice_context.sv
context_read_mux.sv
au_pipeline.sv
au_cluster.sv
au_cluster_checker.sv
au_cluster_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the arithmetic cluster testbench with Verilator and run it.
# The run counts as passed only when the pass line shows up in the output.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 \
  --top-module au_cluster_tb \
  -f au_cluster.f \
  -o au_cluster_sim

sim_out=$(./obj_dir/au_cluster_sim 2>&1 || true)
echo "$sim_out"

if grep -q "Simulation finished: PASS" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi
